// ==== source/lc3b_types.sv ====
`default_nettype none

package lc3b_types;

    typedef logic [15:0] lc3b_word;      // Instruction or data word
    typedef logic [1:0]  lc3b_mem_wmask; // Byte-lane enables where bit 1 is the high byte
    typedef logic [1:0]  lc3b_sel2;      // Generic four-way mux select

    typedef enum logic [3:0] {
        op_br   = 4'b0000,
        op_add  = 4'b0001,
        op_ldb  = 4'b0010,
        op_stb  = 4'b0011,
        op_jsr  = 4'b0100,
        op_and  = 4'b0101,
        op_ldr  = 4'b0110,
        op_str  = 4'b0111,
        op_rti  = 4'b1000,
        op_not  = 4'b1001,
        op_ldi  = 4'b1010,
        op_sti  = 4'b1011,
        op_jmp  = 4'b1100,
        op_shf  = 4'b1101,
        op_lea  = 4'b1110,
        op_trap = 4'b1111
    } lc3b_opcode;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_and = 3'b001,
        alu_not = 3'b010
    } lc3b_aluop;

    typedef enum logic {
        mem_idle,
        mem_indirect
    } mem_state;

    // Bit positions of the fields inside the flat control word counted from the LSB
    localparam int CW_OFFSET6MUX      = 0;
    localparam int CW_OFFSETADDERMUX  = 1;
    localparam int CW_MDRMUX          = 2;
    localparam int CW_DESTMUX         = 3;
    localparam int CW_STOREMUX        = 4;
    localparam int CW_BRMUX           = 5;
    localparam int CW_STB_FILTER      = 6;
    localparam int CW_REGFILE_FILTER  = 7;
    localparam int CW_INDIRECT        = 8;
    localparam int CW_MEM_WRITE       = 9;
    localparam int CW_MEM_READ        = 10;
    localparam int CW_LOAD_MDR        = 11;
    localparam int CW_LOAD_MAR        = 12;
    localparam int CW_LOAD_CC         = 13;
    localparam int CW_LOAD_REGFILE    = 14;
    localparam int CW_LOAD_PC         = 15;
    localparam int CW_MARMUX          = 16; // Two bits each from here on
    localparam int CW_REGFILEMUX      = 18;
    localparam int CW_ALUMUX          = 20;
    localparam int CW_PCMUX           = 22;
    localparam int CW_WMASK           = 24;
    localparam int CW_ALUOP           = 26; // Three bits
    localparam int CW_OPCODE          = 29; // Four bits, topmost field
    localparam int CTRL_W             = CW_OPCODE + 4;

endpackage : lc3b_types

`default_nettype wire

// ==== source/control_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_rom import lc3b_types::*; (
    input  wire lc3b_opcode     opcode,
    input  wire                 imm_enable,
    input  wire                 stb_high_enable,
    input  wire                 jsr_enable,
    input  wire                 is_nop,
    output lc3b_opcode          ctrl_opcode,
    output lc3b_aluop           aluop,
    output lc3b_mem_wmask       mem_byte_enable,
    output lc3b_sel2            pcmux_sel,
    output lc3b_sel2            alumux_sel,
    output lc3b_sel2            regfilemux_sel,
    output lc3b_sel2            marmux_sel,
    output logic                load_pc,
    output logic                load_regfile,
    output logic                load_cc,
    output logic                load_mar,
    output logic                load_mdr,
    output logic                mem_read,
    output logic                mem_write,
    output logic                indirect_enable,
    output logic                regfile_filter_enable,
    output logic                stb_filter_enable,
    output logic                brmux_sel,
    output logic                storemux_sel,
    output logic                destmux_sel,
    output logic                mdrmux_sel,
    output logic                offsetaddermux_sel,
    output logic                offset6mux_sel
);

    always_comb begin
        // Everything idle except a full-word byte mask and an add
        ctrl_opcode           = opcode;
        aluop                 = alu_add;
        mem_byte_enable       = 2'b11;
        pcmux_sel             = 2'b00;
        alumux_sel            = 2'b00;
        regfilemux_sel        = 2'b00;
        marmux_sel            = 2'b00;
        load_pc               = 1'b0;
        load_regfile          = 1'b0;
        load_cc               = 1'b0;
        load_mar              = 1'b0;
        load_mdr              = 1'b0;
        mem_read              = 1'b0;
        mem_write             = 1'b0;
        indirect_enable       = 1'b0;
        regfile_filter_enable = 1'b0;
        stb_filter_enable     = 1'b0;
        brmux_sel             = 1'b0;
        storemux_sel          = 1'b0;
        destmux_sel           = 1'b0;
        mdrmux_sel            = 1'b0;
        offsetaddermux_sel    = 1'b0;
        offset6mux_sel        = 1'b0;

        case (opcode)
            op_add, op_and: begin
                aluop        = (opcode == op_and) ? alu_and : alu_add;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
                if (imm_enable) begin
                    alumux_sel = 2'b10; // Second operand is SEXT(imm5)
                end
            end
            op_not: begin
                aluop        = alu_not;
                load_regfile = 1'b1;
                load_cc      = 1'b1;
            end
            op_ldr, op_ldi, op_ldb: begin
                // Base plus offset goes to MAR, memory data comes back through MDR
                alumux_sel     = 2'b01;
                load_mar       = 1'b1;
                mdrmux_sel     = 1'b1;
                load_mdr       = 1'b1;
                mem_read       = 1'b1;
                regfilemux_sel = 2'b01;
                load_regfile   = 1'b1;
                load_cc        = 1'b1;
                if (opcode == op_ldi) begin
                    indirect_enable = 1'b1; // Loaded word is the address of the data
                end
                if (opcode == op_ldb) begin
                    offset6mux_sel        = 1'b1; // Unscaled byte offset
                    regfile_filter_enable = 1'b1; // Zero-extend the selected byte
                end
            end
            op_str, op_stb: begin
                alumux_sel   = 2'b01;
                load_mar     = 1'b1;
                storemux_sel = 1'b1;
                load_mdr     = 1'b1;
                mem_write    = 1'b1;
                if (opcode == op_stb) begin
                    // Source byte is steered to the lane picked by the address bit
                    offset6mux_sel    = 1'b1;
                    stb_filter_enable = 1'b1;
                    mem_byte_enable   = stb_high_enable ? 2'b10 : 2'b01;
                end
            end
            op_br: begin
                if (!is_nop) begin
                    brmux_sel = 1'b1;
                    load_pc   = 1'b1;
                end
            end
            op_jsr: begin
                destmux_sel    = 1'b1; // Destination forced to R7
                regfilemux_sel = 2'b11; // Return address
                load_regfile   = 1'b1;
                load_pc        = 1'b1;
                if (jsr_enable) begin
                    offsetaddermux_sel = 1'b1;
                    pcmux_sel          = 2'b01;
                end else begin
                    pcmux_sel = 2'b10; // JSRR takes the base register
                end
            end
            op_jmp: begin
                pcmux_sel = 2'b11;
                load_pc   = 1'b1;
            end
            default: begin
                // The defaults are already zero apart from these two fields
                ctrl_opcode     = lc3b_opcode'(4'b0000);
                mem_byte_enable = 2'b00;
            end
        endcase
    end

endmodule : control_rom

`default_nettype wire

// ==== source/ir_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module ir_decode import lc3b_types::*; (
    input  wire lc3b_word    instr,
    input  wire              instr_strobe,
    input  wire              addr_lsb,
    output logic [CTRL_W-1:0] dec_ctrl,
    output logic             dec_valid
);

    lc3b_opcode    opcode;
    logic          imm_enable;
    logic          stb_high_enable;
    logic          jsr_enable;
    logic          is_nop;
    lc3b_opcode    ctrl_opcode;
    lc3b_aluop     aluop;
    lc3b_mem_wmask mem_byte_enable;
    lc3b_sel2      pcmux_sel, alumux_sel, regfilemux_sel, marmux_sel;
    logic          load_pc, load_regfile, load_cc, load_mar, load_mdr;
    logic          mem_read, mem_write, indirect_enable;
    logic          regfile_filter_enable, stb_filter_enable;
    logic          brmux_sel, storemux_sel, destmux_sel, mdrmux_sel;
    logic          offsetaddermux_sel, offset6mux_sel;

    assign opcode          = lc3b_opcode'(instr[15:12]);
    assign imm_enable      = instr[5];
    assign jsr_enable      = instr[11];           // JSR with PC-relative offset
    assign is_nop          = (instr[11:9] == 3'b000); // BR with no condition bits set
    assign stb_high_enable = addr_lsb;
    assign dec_valid       = instr_strobe;

    control_rom i_control_rom (.*);

    // Pack the ROM outputs at the positions fixed in the package
    assign dec_ctrl[CW_OPCODE +: 4]        = ctrl_opcode;
    assign dec_ctrl[CW_ALUOP +: 3]         = aluop;
    assign dec_ctrl[CW_WMASK +: 2]         = mem_byte_enable;
    assign dec_ctrl[CW_PCMUX +: 2]         = pcmux_sel;
    assign dec_ctrl[CW_ALUMUX +: 2]        = alumux_sel;
    assign dec_ctrl[CW_REGFILEMUX +: 2]    = regfilemux_sel;
    assign dec_ctrl[CW_MARMUX +: 2]        = marmux_sel;
    assign dec_ctrl[CW_LOAD_PC]            = load_pc;
    assign dec_ctrl[CW_LOAD_REGFILE]       = load_regfile;
    assign dec_ctrl[CW_LOAD_CC]            = load_cc;
    assign dec_ctrl[CW_LOAD_MAR]           = load_mar;
    assign dec_ctrl[CW_LOAD_MDR]           = load_mdr;
    assign dec_ctrl[CW_MEM_READ]           = mem_read;
    assign dec_ctrl[CW_MEM_WRITE]          = mem_write;
    assign dec_ctrl[CW_INDIRECT]           = indirect_enable;
    assign dec_ctrl[CW_REGFILE_FILTER]     = regfile_filter_enable;
    assign dec_ctrl[CW_STB_FILTER]         = stb_filter_enable;
    assign dec_ctrl[CW_BRMUX]              = brmux_sel;
    assign dec_ctrl[CW_STOREMUX]           = storemux_sel;
    assign dec_ctrl[CW_DESTMUX]            = destmux_sel;
    assign dec_ctrl[CW_MDRMUX]             = mdrmux_sel;
    assign dec_ctrl[CW_OFFSETADDERMUX]     = offsetaddermux_sel;
    assign dec_ctrl[CW_OFFSET6MUX]         = offset6mux_sel;

endmodule : ir_decode

`default_nettype wire

// ==== source/ctrl_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module ctrl_pipe import lc3b_types::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               hold,
    input  wire  [CTRL_W-1:0] dec_ctrl,
    input  wire               dec_valid,
    output logic [CTRL_W-1:0] mem_ctrl,
    output logic              mem_ctrl_valid
);

    logic [CTRL_W-1:0] ex_ctrl;  // Execute-stage control word
    logic              ex_valid;

    // Valid bits shift decode to execute to memory unless the memory stage holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid       <= 1'b0;
            mem_ctrl_valid <= 1'b0;
        end else if (!hold) begin
            ex_valid       <= dec_valid;
            mem_ctrl_valid <= ex_valid;
        end
    end

    // Payload follows the same shift as the valid bits
    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_ctrl  <= dec_ctrl;
            mem_ctrl <= ex_ctrl;
        end
    end

endmodule : ctrl_pipe

`default_nettype wire

// ==== source/mem_stage_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mem_stage_ctrl import lc3b_types::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire  [CTRL_W-1:0] mem_ctrl,
    input  wire               mem_ctrl_valid,
    output logic              hold,
    output logic              mem_read,
    output logic              mem_write,
    output lc3b_mem_wmask     mem_byte_enable,
    output logic              mem_indirect,
    output logic              load_regfile,
    output logic              load_cc,
    output logic              load_pc,
    output lc3b_sel2          pcmux_sel,
    output lc3b_sel2          regfilemux_sel,
    output lc3b_sel2          alumux_sel,
    output lc3b_aluop         aluop,
    output lc3b_opcode        opcode_mem,
    output logic              mem_valid
);

    mem_state state;
    mem_state state_next;
    logic     ind_first;   // Address read of an LDI
    logic     ind_second;  // Data read of an LDI
    logic     wb_enable;

    assign ind_first  = mem_ctrl_valid && mem_ctrl[CW_INDIRECT] && (state == mem_idle);
    assign ind_second = mem_ctrl_valid && (state == lc3b_types::mem_indirect);
    assign wb_enable  = mem_ctrl_valid && !ind_first;

    always_comb begin
        state_next = state;
        case (state)
            mem_idle: begin
                if (ind_first) begin
                    state_next = lc3b_types::mem_indirect;
                end
            end
            default: state_next = mem_idle; // Second access always takes a single cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= mem_idle;
        end else begin
            state <= state_next;
        end
    end

    // The pipe stays frozen for exactly the address-read cycle
    assign hold      = ind_first;
    assign mem_valid = mem_ctrl_valid;

    // Both LDI cycles issue a memory read
    assign mem_read        = mem_ctrl_valid && mem_ctrl[CW_MEM_READ];
    assign mem_write       = mem_ctrl_valid && mem_ctrl[CW_MEM_WRITE];
    assign mem_byte_enable = mem_ctrl_valid ? mem_ctrl[CW_WMASK +: 2] : 2'b00;
    assign mem_indirect    = ind_second;

    // Writeback waits for the data read when the load is indirect
    assign load_regfile = wb_enable && mem_ctrl[CW_LOAD_REGFILE];
    assign load_cc      = wb_enable && mem_ctrl[CW_LOAD_CC];
    assign load_pc      = wb_enable && mem_ctrl[CW_LOAD_PC];

    assign pcmux_sel      = mem_ctrl_valid ? mem_ctrl[CW_PCMUX +: 2] : 2'b00;
    assign regfilemux_sel = mem_ctrl_valid ? mem_ctrl[CW_REGFILEMUX +: 2] : 2'b00;
    assign alumux_sel     = mem_ctrl_valid ? mem_ctrl[CW_ALUMUX +: 2] : 2'b00;
    assign aluop          = lc3b_aluop'(mem_ctrl_valid ? mem_ctrl[CW_ALUOP +: 3] : 3'b000);
    assign opcode_mem     = lc3b_opcode'(mem_ctrl_valid ? mem_ctrl[CW_OPCODE +: 4] : 4'b0000);

endmodule : mem_stage_ctrl

`default_nettype wire

// ==== source/lc3b_ctrl_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_ctrl_top import lc3b_types::*; (
    input  wire            clk,
    input  wire            rst_n,
    input  wire            instr_strobe,
    input  wire lc3b_word  instr,
    input  wire            addr_lsb,
    output logic           mem_read,
    output logic           mem_write,
    output lc3b_mem_wmask  mem_byte_enable,
    output logic           mem_indirect,
    output logic           load_regfile,
    output logic           load_cc,
    output logic           load_pc,
    output lc3b_sel2       pcmux_sel,
    output lc3b_sel2       regfilemux_sel,
    output lc3b_sel2       alumux_sel,
    output lc3b_aluop      aluop,
    output lc3b_opcode     opcode_mem,
    output logic           mem_valid,
    output logic           hold
);

    logic [CTRL_W-1:0] dec_ctrl;
    logic              dec_valid;
    logic [CTRL_W-1:0] mem_ctrl;
    logic              mem_ctrl_valid;

    ir_decode i_ir_decode (
        .instr        (instr),
        .instr_strobe (instr_strobe),
        .addr_lsb     (addr_lsb),
        .dec_ctrl     (dec_ctrl),
        .dec_valid    (dec_valid)
    );

    ctrl_pipe i_ctrl_pipe (
        .clk            (clk),
        .rst_n          (rst_n),
        .hold           (hold),
        .dec_ctrl       (dec_ctrl),
        .dec_valid      (dec_valid),
        .mem_ctrl       (mem_ctrl),
        .mem_ctrl_valid (mem_ctrl_valid)
    );

    // Memory stage feeds hold back into the pipe
    mem_stage_ctrl i_mem_stage_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .mem_ctrl        (mem_ctrl),
        .mem_ctrl_valid  (mem_ctrl_valid),
        .hold            (hold),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_indirect    (mem_indirect),
        .load_regfile    (load_regfile),
        .load_cc         (load_cc),
        .load_pc         (load_pc),
        .pcmux_sel       (pcmux_sel),
        .regfilemux_sel  (regfilemux_sel),
        .alumux_sel      (alumux_sel),
        .aluop           (aluop),
        .opcode_mem      (opcode_mem),
        .mem_valid       (mem_valid)
    );

endmodule : lc3b_ctrl_top

`default_nettype wire

// ==== tb/lc3b_ctrl_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_ctrl_props (
    input wire clk,
    input wire rst_n,
    input wire hold,
    input wire mem_read,
    input wire mem_write,
    input wire mem_indirect,
    input wire load_regfile,
    input wire load_cc,
    input wire load_pc,
    input wire mem_ctrl_valid
);

    int fail_count = 0; // Assertion failures seen so far

    // An LDI stalls the pipe for its address read only
    hold_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) hold |=> !hold)
        else begin
            fail_count++;
            $error("hold stayed high for a second cycle");
        end

    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(mem_read && mem_write))
        else begin
            fail_count++;
            $error("mem_read and mem_write are high together");
        end

    quiet_when_invalid: assert property (@(posedge clk) disable iff (!rst_n)
        !mem_ctrl_valid |-> !(mem_read || mem_write || mem_indirect || load_regfile
                              || load_cc || load_pc))
        else begin
            fail_count++;
            $error("a strobe is high while the memory stage holds no valid word");
        end

endmodule : lc3b_ctrl_props

bind mem_stage_ctrl lc3b_ctrl_props i_props (.*);

`default_nettype wire

// ==== tb/lc3b_ctrl_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_ctrl_checker (
    input  wire        clk,
    input  wire        rst_n,
    input  wire        exp_push,
    input  wire [19:0] exp_rec,   // {opcode, read, write, byte_en, ld_reg, ld_cc, ld_pc, muxes, aluop}
    input  wire [15:0] exp_line,
    input  wire        mem_read,
    input  wire        mem_write,
    input  wire [1:0]  mem_byte_enable,
    input  wire        mem_indirect,
    input  wire        load_regfile,
    input  wire        load_cc,
    input  wire        load_pc,
    input  wire [1:0]  pcmux_sel,
    input  wire [1:0]  regfilemux_sel,
    input  wire [1:0]  alumux_sel,
    input  wire [2:0]  aluop,
    input  wire [3:0]  opcode_mem,
    input  wire        mem_valid,
    input  wire        hold,
    output int         errors,
    output int         checked,
    output int         pending
);

    logic [19:0] exp_q [$];
    logic [15:0] line_q [$];
    logic [19:0] rec;
    logic [15:0] line_no;
    logic        ind_due;   // Data read of an LDI comes in this cycle
    logic [15:0] ind_line;

    initial begin
        errors  = 0;
        checked = 0;
        pending = 0;
        ind_due = 1'b0;
    end

    // RTI, STI, SHF, LEA and TRAP have no ROM entry and leave a zero word
    function automatic logic [3:0] expected_opcode(input logic [3:0] op);
        case (op)
            4'b1000, 4'b1011, 4'b1101, 4'b1110, 4'b1111: expected_opcode = 4'b0000;
            default: expected_opcode = op;
        endcase
    endfunction

    task automatic compare(input logic [15:0] entry, input string field,
                           input logic [3:0] expected, input logic [3:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAIL entry %0d %s: expected %0h, actual %0h", entry, field, expected,
                     actual);
        end
    endtask

    always @(negedge clk) begin
        if (!rst_n) begin
            ind_due = 1'b0;
        end else begin
            if (exp_push) begin
                exp_q.push_back(exp_rec);
                line_q.push_back(exp_line);
            end
            if (ind_due) begin
                compare(ind_line, "mem_indirect", 1, mem_indirect);
                compare(ind_line, "mem_valid", 1, mem_valid);
                compare(ind_line, "mem_read", 1, mem_read);
                compare(ind_line, "mem_write", 0, mem_write);
                compare(ind_line, "load_regfile", 1, load_regfile);
                compare(ind_line, "load_cc", 1, load_cc);
                compare(ind_line, "hold", 0, hold);
                ind_due = 1'b0;
            end else if (mem_valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("The memory stage shows a valid word that was never issued");
                end else begin
                    rec     = exp_q.pop_front();
                    line_no = line_q.pop_front();
                    compare(line_no, "mem_read", rec[15], mem_read);
                    compare(line_no, "mem_write", rec[14], mem_write);
                    compare(line_no, "mem_byte_enable", rec[13:12], mem_byte_enable);
                    compare(line_no, "load_regfile", rec[11], load_regfile);
                    compare(line_no, "load_cc", rec[10], load_cc);
                    compare(line_no, "load_pc", rec[9], load_pc);
                    compare(line_no, "pcmux_sel", rec[8:7], pcmux_sel);
                    compare(line_no, "alumux_sel", rec[6:5], alumux_sel);
                    compare(line_no, "regfilemux_sel", rec[4:3], regfilemux_sel);
                    compare(line_no, "aluop", rec[2:0], aluop);
                    compare(line_no, "opcode_mem", expected_opcode(rec[19:16]), opcode_mem);
                    compare(line_no, "mem_indirect", 0, mem_indirect);
                    ind_due  = (rec[19:16] == 4'b1010); // LDI holds for its address read
                    ind_line = line_no;
                    compare(line_no, "hold", ind_due, hold);
                    checked++;
                end
            end else if (mem_read || mem_write || mem_indirect || load_regfile || load_cc
                         || load_pc || hold) begin
                errors++;
                $display("A strobe is high while the memory stage holds no valid word");
            end
            pending = exp_q.size() + ind_due;
        end
    end

endmodule : lc3b_ctrl_checker

`default_nettype wire

// ==== tb/lc3b_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module lc3b_ctrl_tb import lc3b_types::*; ();

    localparam int TRACE_LEN      = 24;
    localparam int TIMEOUT_CYCLES = 4 * TRACE_LEN + 20;

    logic          clk;
    logic          rst_n;
    logic          instr_strobe;
    lc3b_word      instr;
    logic          addr_lsb;
    logic          mem_read, mem_write, mem_indirect, mem_valid, hold;
    logic          load_regfile, load_cc, load_pc;
    lc3b_mem_wmask mem_byte_enable;
    lc3b_sel2      pcmux_sel, regfilemux_sel, alumux_sel;
    lc3b_aluop     aluop;
    lc3b_opcode    opcode_mem;

    logic [63:0]   trace_mem [0:TRACE_LEN-1];
    logic [63:0]   word;
    logic          exp_push;
    logic [19:0]   exp_rec;
    logic [15:0]   exp_line;
    int            errors, checked, pending;
    int            line_idx;
    int            cycles = 0;
    int            total;
    logic          ex_ldi;      // Execute stage holds a valid LDI
    logic          hold_model;  // Expected hold in the current cycle
    logic          hold_next;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    lc3b_ctrl_top i_lc3b_ctrl_top (.*);

    lc3b_ctrl_checker i_checker (.*);

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("The run timed out after %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    initial begin
        rst_n        = 1'b0;
        instr_strobe = 1'b0;
        instr        = '0;
        addr_lsb     = 1'b0;
        exp_push     = 1'b0;
        exp_rec      = '0;
        exp_line     = '0;
        ex_ldi       = 1'b0;
        hold_model   = 1'b0;
        line_idx     = 0;
        $readmemh("tb/lc3b_ctrl_trace.txt", trace_mem);
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        while (line_idx < TRACE_LEN) begin
            @(posedge clk);
            // An LDI leaving execute stalls the pipe for exactly one cycle
            hold_next = ex_ldi && !hold_model;
            if (!hold_model) ex_ldi = instr_strobe && (instr[15:12] == 4'b1010);
            hold_model = hold_next;
            if (hold_model) begin
                instr_strobe <= 1'b0; // No strobe may arrive during hold
                exp_push     <= 1'b0;
            end else begin
                word = trace_mem[line_idx];
                instr_strobe <= word[60];
                instr        <= word[59:44];
                addr_lsb     <= word[40];
                exp_push     <= word[60];
                exp_rec      <= {word[59:56], word[36], word[32], word[29:28], word[24],
                                 word[20], word[16], word[13:12], word[9:8], word[5:4],
                                 word[2:0]};
                exp_line     <= 16'(line_idx + 1);
                line_idx++;
            end
        end
        @(posedge clk);
        instr_strobe <= 1'b0;
        exp_push     <= 1'b0;
        while (pending != 0) @(posedge clk);
        repeat (3) @(posedge clk); // Idle cycles after the drain must stay quiet
        total = errors + i_lc3b_ctrl_top.i_mem_stage_ctrl.i_props.fail_count;
        $display("Checked %0d instructions, %0d compare errors, %0d assertion failures",
                 checked, errors, i_lc3b_ctrl_top.i_mem_stage_ctrl.i_props.fail_count);
        if (total == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : lc3b_ctrl_tb

`default_nettype wire

// ==== lc3b_ctrl.f ====
source/lc3b_types.sv
source/control_rom.sv
source/ir_decode.sv
source/ctrl_pipe.sv
source/mem_stage_ctrl.sv
source/lc3b_ctrl_top.sv
tb/lc3b_ctrl_props.sv
tb/lc3b_ctrl_checker.sv
tb/lc3b_ctrl_tb.sv

// ==== tb/lc3b_ctrl_trace.txt ====
// issue_instr_addrlsb_memread_memwrite_byteen_loadreg_loadcc_loadpc_pcmux_alumux_regfilemux_aluop
// One hex digit per field except the instruction, expected values are the first memory-stage cycle
1_1283_0_0_0_3_1_1_0_0_0_0_0
1_12a5_0_0_0_3_1_1_0_0_2_0_0
1_5701_0_0_0_3_1_1_0_0_0_0_1
1_573f_0_0_0_3_1_1_0_0_2_0_1
1_9bbf_0_0_0_3_1_1_0_0_0_0_2
1_6042_0_1_0_3_1_1_0_0_1_1_0
1_74c1_0_0_1_3_0_0_0_0_1_0_0
1_34c1_1_0_1_2_0_0_0_0_1_0_0
1_34c1_0_0_1_1_0_0_0_0_1_0_0
1_2283_1_1_0_3_1_1_0_0_1_1_0
0_0000_0_0_0_0_0_0_0_0_0_0_0
1_0005_0_0_0_3_0_0_0_0_0_0_0
1_0e05_0_0_0_3_0_0_1_0_0_0_0
1_4804_0_0_0_3_1_0_1_1_0_3_0
1_40c0_0_0_0_3_1_0_1_2_0_3_0
1_c1c0_0_0_0_3_0_0_1_3_0_0_0
1_a702_0_1_0_3_0_0_0_0_1_1_0
1_1283_0_0_0_3_1_1_0_0_0_0_0
1_a702_0_1_0_3_0_0_0_0_1_1_0
1_a9c4_0_1_0_3_0_0_0_0_1_1_0
1_74c1_0_0_1_3_0_0_0_0_1_0_0
1_f025_0_0_0_0_0_0_0_0_0_0_0
1_d2a1_0_0_0_0_0_0_0_0_0_0_0
1_8000_0_0_0_0_0_0_0_0_0_0_0
